/* verilog/cnn_pkg.sv */
package cnn_pkg;
	localparam int PIX_W = 8;
	localparam int WT_W = 16;
	localparam int K_TAPS = 9;
	localparam int KWORD_W = K_TAPS * WT_W;
	localparam int ROM_DEPTH = 76;
	localparam int KADDR_W = 7;
	localparam int PROD_W = PIX_W + WT_W + 1;	// pixel gets a zero sign bit
	localparam int ACC_W = 28;
	localparam int OUT_W = 16;
	localparam int SHIFT_W = 4;
	localparam int IMG_W = 8;
	localparam int COL_W = $clog2(IMG_W);
	localparam int AXI_AW = 5;
	localparam int AXI_DW = 32;

	// saturation bounds of a signed 16-bit result
	localparam logic signed [ACC_W-1:0] SAT_HI = 32767;
	localparam logic signed [ACC_W-1:0] SAT_LO = -32768;

	localparam logic [AXI_AW-1:0] REG_KSEL_A = 5'h00;
	localparam logic [AXI_AW-1:0] REG_KSEL_B = 5'h04;
	localparam logic [AXI_AW-1:0] REG_SHIFT = 5'h08;
	localparam logic [AXI_AW-1:0] REG_CTRL = 5'h0c;	// bit 0 clears frame
	localparam logic [AXI_AW-1:0] REG_COUNT = 5'h10;	// read only

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
endpackage

/* verilog/wt_rom.sv */
`timescale 1ns/1ns

module wt_rom (
	input  logic clk,
	input  logic [cnn_pkg::KADDR_W-1:0] addr_a,
	input  logic [cnn_pkg::KADDR_W-1:0] addr_b,
	output logic [cnn_pkg::KWORD_W-1:0] q_a,
	output logic [cnn_pkg::KWORD_W-1:0] q_b
);
	import cnn_pkg::*;

	// one 3x3 kernel per word, tap k in bits [16k +: 16]
	logic [KWORD_W-1:0] mem [ROM_DEPTH];

	initial begin
		$readmemh("verilog/weights.hex", mem);
	end

	always_ff @(posedge clk) begin
		q_a <= mem[addr_a];
	end

	always_ff @(posedge clk) begin
		q_b <= mem[addr_b];
	end

endmodule

/* verilog/window_buf.sv */
`timescale 1ns/1ns

module window_buf (
	input  logic clk,
	input  logic reset,
	input  logic frame_clear,
	input  logic stall,
	input  logic pix_valid,
	input  logic [cnn_pkg::PIX_W-1:0] pix_data,
	output logic [cnn_pkg::K_TAPS*cnn_pkg::PIX_W-1:0] win,
	output logic win_valid
);
	import cnn_pkg::*;

	logic [PIX_W-1:0] line1 [IMG_W];	// previous row
	logic [PIX_W-1:0] line2 [IMG_W];	// row before that
	logic [PIX_W-1:0] tap1;
	logic [PIX_W-1:0] tap2;
	logic [PIX_W-1:0] w [3][3];	// [row][col], row 0 oldest, col 2 newest
	logic [COL_W-1:0] col;
	logic [1:0] row;	// saturates at 2
	logic take;

	assign take = pix_valid && !stall;
	assign tap1 = line1[col];
	assign tap2 = line2[col];

	always_ff @(posedge clk) begin
		if (take) begin
			line1[col] <= pix_data;
			line2[col] <= tap1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			for (int r = 0; r < 3; r++) begin
				w[r][0] <= w[r][1];
				w[r][1] <= w[r][2];
			end
			w[0][2] <= tap2;
			w[1][2] <= tap1;
			w[2][2] <= pix_data;
		end
	end

	// tap index is row*3 + col
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				win[(r*3+c)*PIX_W +: PIX_W] = w[r][c];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || frame_clear) begin
			col <= '0;
			row <= '0;
		end else if (take) begin
			if (col == COL_W'(IMG_W-1)) begin
				col <= '0;
				if (row != 2'd2)
					row <= row + 2'd1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			win_valid <= 1'b0;
		else if (!stall)
			win_valid <= take && col >= COL_W'(2) && row == 2'd2;	// no padding
	end

endmodule

/* verilog/conv_mac.sv */
`timescale 1ns/1ns

module conv_mac (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic in_valid,
	input  logic [cnn_pkg::K_TAPS*cnn_pkg::PIX_W-1:0] win,
	input  logic [cnn_pkg::KWORD_W-1:0] kern,
	input  logic [cnn_pkg::SHIFT_W-1:0] shift,
	output logic [cnn_pkg::OUT_W-1:0] res,
	output logic res_valid
);
	import cnn_pkg::*;

	logic signed [PROD_W-1:0] prod [K_TAPS];
	logic signed [ACC_W-1:0] sum;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] shifted;
	logic v1;
	logic v2;

	always_ff @(posedge clk) begin
		if (!stall) begin
			for (int k = 0; k < K_TAPS; k++) begin
				prod[k] <= $signed({1'b0, win[k*PIX_W +: PIX_W]}) *
					$signed(kern[k*WT_W +: WT_W]);
			end
		end
	end

	always_comb begin
		sum = '0;
		for (int k = 0; k < K_TAPS; k++) begin
			sum = sum + prod[k];	// sign extends to ACC_W
		end
	end

	assign shifted = acc >>> shift;

	always_ff @(posedge clk) begin
		if (!stall) begin
			acc <= sum;
			if (shifted > SAT_HI)
				res <= 16'h7fff;
			else if (shifted < SAT_LO)
				res <= 16'h8000;
			else
				res <= shifted[OUT_W-1:0];
		end
	end

	// valid bits follow the data through all three stages
	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			res_valid <= 1'b0;
		end else if (!stall) begin
			v1 <= in_valid;
			v2 <= v1;
			res_valid <= v2;
		end
	end

endmodule

/* verilog/conv_regs.sv */
`timescale 1ns/1ns

module conv_regs (
	input  logic clk,
	input  logic reset,
	input  logic [cnn_pkg::AXI_AW-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [cnn_pkg::AXI_DW-1:0] wdata,
	input  logic [cnn_pkg::AXI_DW/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [cnn_pkg::AXI_AW-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [cnn_pkg::AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic out_fire,
	output logic [cnn_pkg::KADDR_W-1:0] ksel_a,
	output logic [cnn_pkg::KADDR_W-1:0] ksel_b,
	output logic [cnn_pkg::SHIFT_W-1:0] shift,
	output logic frame_clear
);
	import cnn_pkg::*;

	logic aw_full;
	logic w_full;
	logic [AXI_AW-1:0] wr_addr;
	logic [7:0] wr_byte;	// all fields fit in byte lane 0
	logic wr_lane0;
	logic wr_ok;
	logic do_write;
	logic [AXI_DW-1:0] count;
	logic [AXI_DW-1:0] rd_data;
	logic [1:0] rd_resp;

	assign do_write = aw_full && w_full && !bvalid;
	assign wr_ok = wr_addr inside {REG_KSEL_A, REG_KSEL_B, REG_SHIFT, REG_CTRL};

	always_ff @(posedge clk) begin
		if (awvalid && awready)
			wr_addr <= awaddr;
		if (wvalid && wready) begin
			wr_byte <= wdata[7:0];
			wr_lane0 <= wstrb[0];
		end
		if (do_write)
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (arvalid && arready) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			aw_full <= 1'b0;
			w_full <= 1'b0;
			bvalid <= 1'b0;
			ksel_a <= '0;
			ksel_b <= '0;
			shift <= '0;
			frame_clear <= 1'b0;
		end else begin
			awready <= awvalid && !awready && !aw_full && !bvalid;	// one-cycle pulse
			wready <= wvalid && !wready && !w_full && !bvalid;
			if (awvalid && awready)
				aw_full <= 1'b1;
			if (wvalid && wready)
				w_full <= 1'b1;
			frame_clear <= 1'b0;
			if (do_write) begin
				aw_full <= 1'b0;
				w_full <= 1'b0;
				bvalid <= 1'b1;
				if (wr_lane0) begin
					case (wr_addr)
						REG_KSEL_A: ksel_a <= wr_byte[KADDR_W-1:0];
						REG_KSEL_B: ksel_b <= wr_byte[KADDR_W-1:0];
						REG_SHIFT: shift <= wr_byte[SHIFT_W-1:0];
						REG_CTRL: frame_clear <= wr_byte[0];
						default: ;
					endcase
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (araddr)
			REG_KSEL_A: rd_data = AXI_DW'(ksel_a);
			REG_KSEL_B: rd_data = AXI_DW'(ksel_b);
			REG_SHIFT: rd_data = AXI_DW'(shift);
			REG_CTRL: rd_data = '0;	// write only
			REG_COUNT: rd_data = count;
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (out_fire)
			count <= count + 1'b1;	// wraps
	end

endmodule

/* verilog/conv_top.sv */
`timescale 1ns/1ns

module conv_top (
	input  logic clk,
	input  logic reset,
	input  logic [cnn_pkg::AXI_AW-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [cnn_pkg::AXI_DW-1:0] wdata,
	input  logic [cnn_pkg::AXI_DW/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [cnn_pkg::AXI_AW-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [cnn_pkg::AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic pix_valid,
	output logic pix_ready,
	input  logic [cnn_pkg::PIX_W-1:0] pix_data,
	output logic out_valid,
	input  logic out_ready,
	output logic [cnn_pkg::OUT_W-1:0] out_a,
	output logic [cnn_pkg::OUT_W-1:0] out_b
);
	import cnn_pkg::*;

	logic [KADDR_W-1:0] ksel_a;
	logic [KADDR_W-1:0] ksel_b;
	logic [SHIFT_W-1:0] shift;
	logic frame_clear;
	logic [KWORD_W-1:0] kern_a;
	logic [KWORD_W-1:0] kern_b;
	logic [K_TAPS*PIX_W-1:0] win;
	logic win_valid;
	logic stall;
	logic out_fire;

	// held result freezes the whole pipeline
	assign stall = out_valid && !out_ready;
	assign pix_ready = !stall;
	assign out_fire = out_valid && out_ready;

	conv_regs u_regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.out_fire(out_fire),
		.ksel_a(ksel_a), .ksel_b(ksel_b), .shift(shift), .frame_clear(frame_clear)
	);

	wt_rom u_rom (
		.clk(clk), .addr_a(ksel_a), .addr_b(ksel_b), .q_a(kern_a), .q_b(kern_b)
	);

	window_buf u_win (
		.clk(clk), .reset(reset), .frame_clear(frame_clear), .stall(stall),
		.pix_valid(pix_valid), .pix_data(pix_data), .win(win), .win_valid(win_valid)
	);

	conv_mac u_mac_a (
		.clk(clk), .reset(reset), .stall(stall), .in_valid(win_valid), .win(win),
		.kern(kern_a), .shift(shift), .res(out_a), .res_valid(out_valid)
	);

	// same valid timing as channel a
	conv_mac u_mac_b (
		.clk(clk), .reset(reset), .stall(stall), .in_valid(win_valid), .win(win),
		.kern(kern_b), .shift(shift), .res(out_b), .res_valid()
	);

endmodule

/* verif/conv_chk.sv */
`timescale 1ns/1ns

module conv_chk (
	input  logic clk,
	input  logic reset,
	input  logic out_valid,
	input  logic out_ready,
	input  logic [cnn_pkg::OUT_W-1:0] out_a,
	input  logic [cnn_pkg::OUT_W-1:0] out_b,
	input  logic pix_ready,
	input  logic bvalid,
	input  logic bready,
	input  logic rvalid,
	input  logic rready
);
	import cnn_pkg::*;

	// result stream holds while stalled
	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_a) && $stable(out_b))
		else $error("result stream changed before out_ready");

	a_pix_ready: assert property (@(posedge clk) disable iff (reset)
		pix_ready == !(out_valid && !out_ready))
		else $error("pix_ready does not follow the stall");

	a_b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	a_reset_out: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high right after reset");

endmodule

/* verif/conv_tb.sv */
`timescale 1ns/1ns

module conv_tb;
	import cnn_pkg::*;

	localparam int PIX_TOTAL = 32 + 48 + 32 + 43;
	localparam int WD_LIMIT = (4 * PIX_TOTAL + 200) * 10;	// ns

	logic clk;
	logic reset;
	logic [AXI_AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DW-1:0] wdata;
	logic [AXI_DW/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_AW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DW-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic pix_valid;
	logic pix_ready;
	logic [PIX_W-1:0] pix_data;
	logic out_valid;
	logic out_ready = 1'b1;
	logic [OUT_W-1:0] out_a;
	logic [OUT_W-1:0] out_b;

	logic [KWORD_W-1:0] rom_model [ROM_DEPTH];
	logic [31:0] lfsr;
	logic [PIX_W-1:0] frame [64];
	logic [OUT_W-1:0] exp_a [$];
	logic [OUT_W-1:0] exp_b [$];
	logic [OUT_W-1:0] ea;
	logic [OUT_W-1:0] eb;
	logic [PIX_W-1:0] ln0 [IMG_W];	// model rows, ln2 is current
	logic [PIX_W-1:0] ln1 [IMG_W];
	logic [PIX_W-1:0] ln2 [IMG_W];
	logic [KADDR_W-1:0] cur_ka;
	logic [KADDR_W-1:0] cur_kb;
	logic [SHIFT_W-1:0] cur_shift;
	logic bp_on = 1'b0;
	int m_col;
	int m_row;
	int errors;
	int fires;
	int tests_passed;
	int tests_failed;

	conv_top DUT (.*);

	bind conv_top conv_chk u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [OUT_W-1:0] conv_ref(logic [KWORD_W-1:0] kw,
			logic [K_TAPS*PIX_W-1:0] w, logic [SHIFT_W-1:0] sh);
		int sum;
		int s;
		sum = 0;
		for (int k = 0; k < K_TAPS; k++)
			sum += int'(w[k*PIX_W +: PIX_W]) * int'($signed(kw[k*WT_W +: WT_W]));
		s = sum >>> sh;
		if (s > 32767)
			return 16'h7fff;
		if (s < -32768)
			return 16'h8000;
		return s[15:0];
	endfunction

	task automatic model_pixel(logic [PIX_W-1:0] p);
		logic [K_TAPS*PIX_W-1:0] w;
		ln2[m_col] = p;
		if (m_col >= 2 && m_row >= 2) begin
			for (int c = 0; c < 3; c++) begin
				w[(0*3+c)*PIX_W +: PIX_W] = ln0[m_col-2+c];
				w[(1*3+c)*PIX_W +: PIX_W] = ln1[m_col-2+c];
				w[(2*3+c)*PIX_W +: PIX_W] = ln2[m_col-2+c];
			end
			exp_a.push_back(conv_ref(rom_model[cur_ka], w, cur_shift));
			exp_b.push_back(conv_ref(rom_model[cur_kb], w, cur_shift));
		end
		if (m_col == IMG_W - 1) begin
			m_col = 0;
			m_row++;
			ln0 = ln1;
			ln1 = ln2;
		end else begin
			m_col++;
		end
	endtask

	task automatic check_eq(string name, logic [31:0] e, logic [31:0] a);
		assert (e == a) else begin
			$display("[ERROR] %s expected 0x%h got 0x%h", name, e, a);
			errors++;
		end
	endtask

	task automatic axi_write(logic [AXI_AW-1:0] addr, logic [31:0] data, int order,
			output logic [1:0] resp);
		bit aw_done;
		bit w_done;
		bit aw_hit;
		bit w_hit;
		aw_done = 0;
		w_done = 0;
		@(posedge clk);
		if (order != 2) begin	// 1 sends aw first, 2 sends w first
			awaddr <= addr;
			awvalid <= 1'b1;
		end
		if (order != 1) begin
			wdata <= data;
			wstrb <= 4'hf;
			wvalid <= 1'b1;
		end
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			aw_hit = awvalid && awready;
			w_hit = wvalid && wready;
			@(posedge clk);
			if (aw_hit) begin
				awvalid <= 1'b0;
				aw_done = 1;
				if (order == 1) begin
					wdata <= data;
					wstrb <= 4'hf;
					wvalid <= 1'b1;
				end
			end
			if (w_hit) begin
				wvalid <= 1'b0;
				w_done = 1;
				if (order == 2) begin
					awaddr <= addr;
					awvalid <= 1'b1;
				end
			end
		end
		do @(negedge clk); while (!bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b1;	// bvalid waits a cycle for ready
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(logic [AXI_AW-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b1;	// rvalid waits a cycle for ready
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_expect(logic [AXI_AW-1:0] addr, logic [31:0] data, int order,
			logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, order, resp);
		check_eq("bresp", exp_resp, resp);
	endtask

	task automatic read_expect(logic [AXI_AW-1:0] addr, logic [31:0] exp_data,
			logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_eq("rdata", exp_data, data);
		check_eq("rresp", exp_resp, resp);
	endtask

	// indices change only with the pipeline empty
	task automatic set_kernels(logic [KADDR_W-1:0] ka, logic [KADDR_W-1:0] kb,
			logic [SHIFT_W-1:0] sh);
		write_expect(REG_KSEL_A, ka, 0, RESP_OKAY);
		write_expect(REG_KSEL_B, kb, 0, RESP_OKAY);
		write_expect(REG_SHIFT, sh, 0, RESP_OKAY);
		cur_ka = ka;
		cur_kb = kb;
		cur_shift = sh;
	endtask

	task automatic fill_frame(int n, bit all_max);
		for (int i = 0; i < n; i++)
			frame[i] = all_max ? 8'hff : rand_bits(8);
	endtask

	task automatic send_frame(int n);
		int idx;
		bit hit;
		idx = 0;
		@(posedge clk);
		pix_valid <= 1'b1;
		pix_data <= frame[0];
		while (idx < n) begin
			@(negedge clk);
			hit = pix_ready;
			if (hit)
				model_pixel(frame[idx]);
			@(posedge clk);
			if (hit) begin
				idx++;
				if (idx < n)
					pix_data <= frame[idx];
				else
					pix_valid <= 1'b0;
			end
		end
	endtask

	task automatic wait_idle();
		while (exp_a.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	task automatic end_test(string name, int err0);
		if (errors == err0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err0);
		end
	endtask

	function automatic logic [KADDR_W-1:0] rand_kernel();
		return KADDR_W'(rand_bits(KADDR_W) % ROM_DEPTH);
	endfunction

	always @(posedge clk) begin
		if (reset)
			out_ready <= 1'b1;
		else
			out_ready <= bp_on ? rand_bits(1) != 0 : 1'b1;
	end

	// result monitor
	always @(negedge clk) begin
		if (!reset && out_valid && out_ready) begin
			fires++;
			if (exp_a.size() == 0) begin
				$display("result transfer arrived with no window pending");
				errors++;
			end else begin
				ea = exp_a.pop_front();
				eb = exp_b.pop_front();
				check_eq("out_a", ea, out_a);
				check_eq("out_b", eb, out_b);
			end
		end
	end

	initial begin
		#(WD_LIMIT);
		$display("timeout: run still busy after %0d ns", WD_LIMIT);
		$display("sim failed");
		$finish;
	end

	initial begin
		int err0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		pix_valid = 1'b0;
		pix_data = '0;
		lfsr = 32'h4b5d;
		errors = 0;
		fires = 0;
		tests_passed = 0;
		tests_failed = 0;
		m_col = 0;
		m_row = 0;
		cur_ka = '0;
		cur_kb = '0;
		cur_shift = '0;
		$readmemh("verilog/weights.hex", rom_model);
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		err0 = errors;
		write_expect(REG_KSEL_A, 32'd37, 0, RESP_OKAY);
		write_expect(REG_KSEL_B, 32'd75, 1, RESP_OKAY);	// aw before w
		write_expect(REG_SHIFT, 32'd9, 2, RESP_OKAY);	// w before aw
		read_expect(REG_KSEL_A, 32'd37, RESP_OKAY);
		read_expect(REG_KSEL_B, 32'd75, RESP_OKAY);
		read_expect(REG_SHIFT, 32'd9, RESP_OKAY);
		read_expect(REG_CTRL, 32'd0, RESP_OKAY);
		read_expect(5'h14, 32'd0, RESP_SLVERR);
		write_expect(REG_COUNT, 32'd5, 0, RESP_SLVERR);
		read_expect(REG_COUNT, 32'd0, RESP_OKAY);
		end_test("registers", err0);

		err0 = errors;
		set_kernels(rand_kernel(), rand_kernel(), SHIFT_W'(rand_bits(3)));
		fill_frame(32, 0);
		send_frame(32);
		wait_idle();
		end_test("convolution", err0);

		err0 = errors;
		set_kernels(rand_kernel(), rand_kernel(), 4'd0);
		fill_frame(24, 1);
		send_frame(24);
		wait_idle();
		set_kernels(rand_kernel(), rand_kernel(), 4'd15);
		fill_frame(24, 0);
		send_frame(24);
		wait_idle();
		end_test("shift and saturation", err0);

		err0 = errors;
		set_kernels(rand_kernel(), rand_kernel(), SHIFT_W'(rand_bits(3)));
		fill_frame(32, 0);
		bp_on = 1'b1;
		send_frame(32);
		wait_idle();
		bp_on = 1'b0;
		end_test("back-pressure", err0);

		err0 = errors;
		set_kernels(rand_kernel(), rand_kernel(), SHIFT_W'(rand_bits(3)));
		fill_frame(19, 0);
		send_frame(19);	// stops mid-row
		wait_idle();
		write_expect(REG_CTRL, 32'd1, 0, RESP_OKAY);
		m_col = 0;
		m_row = 0;
		fill_frame(24, 0);
		send_frame(24);
		wait_idle();
		read_expect(REG_COUNT, fires, RESP_OKAY);
		end_test("frame clear and counter", err0);

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* sources.f */
verilog/cnn_pkg.sv
verilog/wt_rom.sv
verilog/window_buf.sv
verilog/conv_mac.sv
verilog/conv_regs.sv
verilog/conv_top.sv
verif/conv_chk.sv
verif/conv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the conv_top testbench with Verilator.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_tb -f sources.f --Mdir obj_dir -o conv_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/conv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
exit 0

/* verilog/weights.hex */
// one 3x3 kernel per line: nine signed 16-bit weights, tap 8 first, tap 0 last
0001fffe7a318c050010ffd31234edcb0400
fffe7a318c050010ffd31234edcb0400fc00
7a318c050010ffd31234edcb0400fc003fff
8c050010ffd31234edcb0400fc003fffc001
0010ffd31234edcb0400fc003fffc0010007
ffd31234edcb0400fc003fffc0010007fff9
1234edcb0400fc003fffc0010007fff92a2a
edcb0400fc003fffc0010007fff92a2ad5d6
0400fc003fffc0010007fff92a2ad5d600ff
fc003fffc0010007fff92a2ad5d600ffff01
3fffc0010007fff92a2ad5d600ffff015a5a
c0010007fff92a2ad5d600ffff015a5aa5a6
0007fff92a2ad5d600ffff015a5aa5a60001
fff92a2ad5d600ffff015a5aa5a60001fffe
2a2ad5d600ffff015a5aa5a60001fffe7a31
d5d600ffff015a5aa5a60001fffe7a318c05
00ffff015a5aa5a60001fffe7a318c050010
ff015a5aa5a60001fffe7a318c050010ffd3
5a5aa5a60001fffe7a318c050010ffd31234
a5a60001fffe7a318c050010ffd31234edcb
00018c051234fc000007d5d65a5afffe0010
8c051234fc000007d5d65a5afffe0010edcb
1234fc000007d5d65a5afffe0010edcb3fff
fc000007d5d65a5afffe0010edcb3ffffff9
0007d5d65a5afffe0010edcb3ffffff900ff
d5d65a5afffe0010edcb3ffffff900ffa5a6
5a5afffe0010edcb3ffffff900ffa5a67a31
fffe0010edcb3ffffff900ffa5a67a31ffd3
0010edcb3ffffff900ffa5a67a31ffd30400
edcb3ffffff900ffa5a67a31ffd30400c001
3ffffff900ffa5a67a31ffd30400c0012a2a
fff900ffa5a67a31ffd30400c0012a2aff01
00ffa5a67a31ffd30400c0012a2aff010001
a5a67a31ffd30400c0012a2aff0100018c05
7a31ffd30400c0012a2aff0100018c051234
ffd30400c0012a2aff0100018c051234fc00
0400c0012a2aff0100018c051234fc000007
c0012a2aff0100018c051234fc000007d5d6
2a2aff0100018c051234fc000007d5d65a5a
ff0100018c051234fc000007d5d65a5afffe
0001edcb2a2afffe0400d5d67a31fc0000ff
edcb2a2afffe0400d5d67a31fc0000ff8c05
2a2afffe0400d5d67a31fc0000ff8c053fff
fffe0400d5d67a31fc0000ff8c053fffff01
0400d5d67a31fc0000ff8c053fffff010010
d5d67a31fc0000ff8c053fffff010010c001
7a31fc0000ff8c053fffff010010c0015a5a
fc0000ff8c053fffff010010c0015a5affd3
00ff8c053fffff010010c0015a5affd30007
8c053fffff010010c0015a5affd30007a5a6
3fffff010010c0015a5affd30007a5a61234
ff010010c0015a5affd30007a5a61234fff9
0010c0015a5affd30007a5a61234fff90001
c0015a5affd30007a5a61234fff90001edcb
5a5affd30007a5a61234fff90001edcb2a2a
ffd30007a5a61234fff90001edcb2a2afffe
0007a5a61234fff90001edcb2a2afffe0400
a5a61234fff90001edcb2a2afffe0400d5d6
1234fff90001edcb2a2afffe0400d5d67a31
fff90001edcb2a2afffe0400d5d67a31fc00
0001c0017a31fff90010d5d61234ff010400
c0017a31fff90010d5d61234ff010400a5a6
7a31fff90010d5d61234ff010400a5a63fff
fff90010d5d61234ff010400a5a63ffffffe
0010d5d61234ff010400a5a63ffffffe0007
d5d61234ff010400a5a63ffffffe00078c05
1234ff010400a5a63ffffffe00078c052a2a
ff010400a5a63ffffffe00078c052a2affd3
0400a5a63ffffffe00078c052a2affd300ff
a5a63ffffffe00078c052a2affd300ffedcb
3ffffffe00078c052a2affd300ffedcb5a5a
fffe00078c052a2affd300ffedcb5a5afc00
00078c052a2affd300ffedcb5a5afc000001
8c052a2affd300ffedcb5a5afc000001c001
2a2affd300ffedcb5a5afc000001c0017a31
ffd300ffedcb5a5afc000001c0017a31fff9
